// ==== tb/pmp_patterns.txt ====
# W name offset data | R name offset data pslverr
# A name addr instr write priv fault cause (all hex, priv 0 user, 3 machine)
A nomatch_m    00005000 0 0 3 0 0
W cfg1_rsvd    04 7f7f7f7f
R cfg1_rsvd    04 1f1f1f1f 0
R unmapped_cfg 08 00000000 1
R unmapped_top 60 00000000 1
R misaligned   41 00000000 1
W addr0_tor    40 00000400
W addr1_na4    44 00000800
W addr2_napot  48 00000c1f
R addr2_napot  48 00000c1f 0
W addr3_napot  4c 00000dff
W cfg0_regions 00 1f1c1309
A tor_first    00000000 0 0 0 0 0
A tor_last     00000ffc 0 0 0 0 0
A tor_store    00000ffc 0 1 0 1 7
A tor_out      00001000 0 0 0 1 5
A na4_in       00002000 0 1 0 0 0
A na4_above    00002004 0 0 0 1 5
A napot_first  00003000 1 0 0 0 0
A napot_last   000030fc 1 0 0 0 0
A prio_load    00003000 0 0 0 1 5
A prio_next    00003100 0 0 0 0 0
A napot_above  00004000 0 1 0 1 7
A m_unlocked   00000ffc 0 1 3 0 0
W lock_e0      00 1f1c1389
A m_locked     00000ffc 0 1 3 1 7
W lock_cfg     00 1f1c1100
R lock_cfg     00 1f1c1189 0
W lock_addr    40 00000800
R lock_addr    40 00000400 0
W addr4_wr     50 00001400
W addr5_wr     54 00001800
W tor_lock     04 00008900
A tor_lock_m   00005ffc 1 0 3 1 1
W addr4_blk    50 00002000
R addr4_blk    50 00001400 0

// ==== compile.f ====
+incdir+tb
logic/pmp_pkg.sv
logic/pmp_region_decode.sv
logic/pmp_csr_file.sv
logic/pmp_checker.sv
logic/pmp_unit.sv
tb/pmp_unit_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 --top-module pmp_unit_tb -f compile.f -o pmp_sim
./obj_dir/pmp_sim > sim.log 2>&1
cat sim.log

if grep -qx "Test completed successfully" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

// ==== tb/pmp_checks.svh ====
task automatic check_data(input string name, input logic [31:0] exp,
                          input logic [31:0] act);
  if (act !== exp) begin
    errors++;
    $display("FAILED %s: expected %h, actual %h", name, exp, act);
  end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
  if (act !== exp) begin
    errors++;
    $display("FAILED %s: expected %b, actual %b", name, exp, act);
  end
endtask

task automatic check_rsp(input string name, input pmp_rsp_t exp, input pmp_rsp_t act);
  if (act !== exp) begin
    errors++;
    $display("FAILED %s: expected fault %b cause %0d tval %h, actual fault %b cause %0d tval %h",
             name, exp.fault, exp.cause, exp.tval, act.fault, act.cause, act.tval);
  end
endtask

// ==== tb/pmp_unit_tb.sv ====
`timescale 1ns/1ps

module pmp_unit_tb
  import pmp_pkg::*;
();

  localparam int entries = 8;

  typedef struct packed {
    logic [7:0]       kind;
    logic [127:0]     name;
    logic [5:0][31:0] f;
  } record_t;

  logic         clk = 1'b0;
  logic         rst;
  logic         psel;
  logic         penable;
  logic         pwrite;
  logic [7:0]   paddr;
  logic [31:0]  pwdata;
  logic [31:0]  prdata;
  logic         pready;
  logic         pslverr;
  pmp_req_t     req;
  pmp_rsp_t     rsp;
  record_t      recs[$];
  int           errors = 0;
  int           timeouts = 0;
  int           cycles = 0;
  int           limit = 0;
  logic         pending = 1'b0; // A request whose response is due next negedge.
  string        pend_name;
  pmp_rsp_t     pend_exp;

  `include "pmp_checks.svh"

  pmp_unit #(
    .pmp_entries(entries)
  ) dut_i (
    .clk    (clk),
    .rst    (rst),
    .psel   (psel),
    .penable(penable),
    .pwrite (pwrite),
    .paddr  (paddr),
    .pwdata (pwdata),
    .prdata (prdata),
    .pready (pready),
    .pslverr(pslverr),
    .req    (req),
    .rsp    (rsp)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (limit != 0 && cycles >= limit) begin
      timeouts++;
      $display("Timeout: the run did not finish within %0d cycles", limit);
      $display("Errors: %0d, timeouts: %0d", errors, timeouts);
      $display("Test failed");
      $finish;
    end
  end

  // An offset is mapped only if word aligned and inside the pmpcfg or pmpaddr range.
  function automatic logic offset_unmapped(input logic [7:0] off);
    logic [7:0] cfg_rel;
    logic [7:0] addr_rel;
    cfg_rel  = off - cfg_base;
    addr_rel = off - addr_base;
    return (off[1:0] != 2'b00) || (cfg_rel >= 8'(entries) && addr_rel >= 8'(4 * entries));
  endfunction

  task automatic read_patterns();
    int      fd;
    string   line;
    record_t r;
    fd = $fopen("tb/pmp_patterns.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Cannot open the pattern file tb/pmp_patterns.txt");
    end else begin
      while ($fgets(line, fd) != 0) begin
        r = '0;
        if (line.len() > 1 && line[0] != "#") begin
          void'($sscanf(line, "%c %s %h %h %h %h %h %h", r.kind, r.name,
                        r.f[0], r.f[1], r.f[2], r.f[3], r.f[4], r.f[5]));
          recs.push_back(r);
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic settle_response();
    if (pending && !rsp.valid) begin
      errors++;
      $display("Request %s got no response with valid set one cycle later", pend_name);
    end else if (pending) begin
      check_rsp(pend_name, pend_exp, rsp);
    end else if (rsp.valid) begin
      errors++;
      $display("A response showed valid with no request in flight");
    end
  endtask

  task automatic step_cycle();
    @(posedge clk);
    req.valid <= 1'b0;
    @(negedge clk);
    settle_response();
    pending = 1'b0;
  endtask

  task automatic issue_access(input record_t r);
    @(posedge clk);
    req <= '{valid: 1'b1, addr: r.f[0], instr: r.f[1][0], write: r.f[2][0],
             priv: priv_e'(r.f[3][1:0])};
    @(negedge clk);
    settle_response(); // The previous request answers while this one is sampled.
    pending   = 1'b1;
    pend_name = $sformatf("%0s", r.name);
    pend_exp  = '{valid: 1'b1, fault: r.f[4][0], cause: r.f[5][3:0],
                  tval: r.f[4][0] ? r.f[0] : 32'd0};
  endtask

  task automatic apb_transfer(input logic write, input logic [7:0] off,
                              input logic [31:0] data, output logic [31:0] rdata,
                              output logic err);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= write;
    paddr   <= off;
    pwdata  <= data;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  initial begin
    logic [31:0] rdata;
    logic        err;
    int          idle;
    rst     <= 1'b0;
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= '0;
    pwdata  <= '0;
    req     <= '0;
    void'($urandom(32'hb701));
    read_patterns();
    limit = 16 + 8 * recs.size() + 100;
    repeat (16) @(posedge clk);
    rst <= 1'b1;
    @(negedge clk);
    check_data("reset_prdata", 32'd0, prdata);
    check_flag("reset_pslverr", 1'b0, pslverr);
    check_flag("reset_pready", 1'b1, pready);
    check_flag("reset_rsp_valid", 1'b0, rsp.valid);
    foreach (recs[i]) begin
      idle = $urandom_range(3, 0);
      repeat (idle) step_cycle();
      if (recs[i].kind == "A") begin
        issue_access(recs[i]);
      end else begin
        if (pending) step_cycle(); // Registers stay still while a request is judged.
        apb_transfer(recs[i].kind == "W", recs[i].f[0][7:0], recs[i].f[1], rdata, err);
        if (recs[i].kind == "R") begin
          check_data($sformatf("%0s", recs[i].name), recs[i].f[1], rdata);
          check_flag($sformatf("%0s", recs[i].name), recs[i].f[2][0], err);
        end else begin
          check_flag($sformatf("%0s", recs[i].name),
                     offset_unmapped(recs[i].f[0][7:0]), err); // Locked writes end cleanly.
        end
      end
    end
    step_cycle();
    step_cycle();
    $display("Errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== logic/pmp_unit.sv ====
`timescale 1ns/1ps

module pmp_unit
  import pmp_pkg::*;
#(
  parameter int pmp_entries = 8
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [7:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  input  pmp_req_t    req,
  output pmp_rsp_t    rsp
);

  pmp_cfg_t [pmp_entries-1:0]     cfg;
  logic [pmp_entries-1:0][31:0]   pmp_addr;
  pmp_region_t [pmp_entries-1:0]  regions;

  pmp_csr_file #(
    .pmp_entries(pmp_entries)
  ) csr_i (
    .clk    (clk),
    .rst    (rst),
    .psel   (psel),
    .penable(penable),
    .pwrite (pwrite),
    .paddr  (paddr),
    .pwdata (pwdata),
    .prdata (prdata),
    .pready (pready),
    .pslverr(pslverr),
    .cfg    (cfg),
    .addr   (pmp_addr)
  );

  for (genvar i = 0; i < pmp_entries; i++) begin : g_region
    if (i == 0) begin : g_first
      pmp_region_decode decode_i (
        .cfg      (cfg[i]),
        .addr     (pmp_addr[i]),
        .prev_addr(32'd0), // Entry 0 in TOR mode starts at address zero.
        .region   (regions[i])
      );
    end else begin : g_rest
      pmp_region_decode decode_i (
        .cfg      (cfg[i]),
        .addr     (pmp_addr[i]),
        .prev_addr(pmp_addr[i-1]),
        .region   (regions[i])
      );
    end
  end

  pmp_checker #(
    .pmp_entries(pmp_entries)
  ) checker_i (
    .clk    (clk),
    .rst    (rst),
    .req    (req),
    .regions(regions),
    .cfg    (cfg),
    .rsp    (rsp)
  );

endmodule

// ==== logic/pmp_checker.sv ====
`timescale 1ns/1ps

module pmp_checker
  import pmp_pkg::*;
#(
  parameter int pmp_entries = 8
) (
  input  logic                          clk,
  input  logic                          rst,
  input  pmp_req_t                      req,
  input  pmp_region_t [pmp_entries-1:0] regions,
  input  pmp_cfg_t [pmp_entries-1:0]    cfg,
  output pmp_rsp_t                      rsp
);

  logic [30:0] req_word;
  logic        hit;
  pmp_cfg_t    hit_cfg;
  logic        perm;
  logic        machine;
  logic        allowed;
  logic        deny;
  logic [3:0]  cause;

  assign req_word = {1'b0, req.addr[31:2]};
  assign machine  = req.priv == priv_machine;

  // Walk from the top down so the lowest matching entry is left standing.
  always_comb begin
    hit     = 1'b0;
    hit_cfg = '0;
    for (int i = pmp_entries - 1; i >= 0; i--) begin
      if (regions[i].active && req_word >= regions[i].lo && req_word < regions[i].hi) begin
        hit     = 1'b1;
        hit_cfg = cfg[i];
      end
    end
  end

  always_comb begin
    if (req.instr) begin
      perm  = hit_cfg.x;
      cause = cause_instr_fault;
    end else if (req.write) begin
      perm  = hit_cfg.w;
      cause = cause_store_fault;
    end else begin
      perm  = hit_cfg.r;
      cause = cause_load_fault;
    end
  end

  // Machine mode is only held to an entry's bits once L is set.
  always_comb begin
    if (hit) begin
      allowed = perm || (machine && !hit_cfg.l);
    end else begin
      allowed = machine;
    end
  end

  assign deny = req.valid && !allowed;

  always_ff @(posedge clk) begin
    if (!rst) begin
      rsp <= '0;
    end else begin
      rsp.valid <= req.valid;
      rsp.fault <= deny;
      rsp.cause <= deny ? cause : 4'd0;
      rsp.tval  <= deny ? req.addr : 32'd0;
    end
  end

endmodule

// ==== logic/pmp_csr_file.sv ====
`timescale 1ns/1ps

module pmp_csr_file
  import pmp_pkg::*;
#(
  parameter int pmp_entries = 8
) (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               psel,
  input  logic                               penable,
  input  logic                               pwrite,
  input  logic [7:0]                         paddr,
  input  logic [31:0]                        pwdata,
  output logic [31:0]                        prdata,
  output logic                               pready,
  output logic                               pslverr,
  output pmp_cfg_t [pmp_entries-1:0]         cfg,
  output logic [pmp_entries-1:0][31:0]       addr
);

  localparam int cfg_words = pmp_entries / 4;

  logic                  access;
  logic [7:0]            cfg_off;
  logic [7:0]            addr_off;
  logic                  cfg_hit;
  logic                  addr_hit;
  pmp_cfg_word_u         wr_word;
  pmp_cfg_word_u         rd_word;
  logic [pmp_entries:0]  tor_lock;
  logic [pmp_entries-1:0] addr_wr_ok;

  assign access   = psel && penable;
  assign pready   = 1'b1; // No wait states.
  assign cfg_off  = paddr - cfg_base; // Wraps high for offsets below the base.
  assign addr_off = paddr - addr_base;
  assign cfg_hit  = (cfg_off < 8'(4 * cfg_words)) && (paddr[1:0] == 2'b00);
  assign addr_hit = (addr_off < 8'(4 * pmp_entries)) && (paddr[1:0] == 2'b00);

  // A locked TOR entry also freezes the pmpaddr just below it.
  always_comb begin
    tor_lock[pmp_entries] = 1'b0;
    for (int i = 0; i < pmp_entries; i++) begin
      tor_lock[i] = cfg[i].l && (cfg[i].a == pmp_tor);
    end
    for (int i = 0; i < pmp_entries; i++) begin
      addr_wr_ok[i] = !cfg[i].l && !tor_lock[i+1];
    end
  end

  always_comb begin
    wr_word.raw = pwdata;
    for (int b = 0; b < 4; b++) begin
      wr_word.entry[b].rsvd = 2'b00;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      cfg  <= '0;
      addr <= '0;
    end else if (access && pwrite) begin
      if (cfg_hit) begin
        for (int k = 0; k < cfg_words; k++) begin
          if (cfg_off[7:2] == 6'(k)) begin
            for (int b = 0; b < 4; b++) begin
              if (!cfg[4*k+b].l) begin
                cfg[4*k+b] <= wr_word.entry[b];
              end
            end
          end
        end
      end
      if (addr_hit) begin
        for (int i = 0; i < pmp_entries; i++) begin
          if (addr_off[7:2] == 6'(i) && addr_wr_ok[i]) begin
            addr[i] <= pwdata;
          end
        end
      end
    end
  end

  always_comb begin
    rd_word.raw = '0;
    prdata      = '0;
    pslverr     = 1'b0;
    if (access) begin
      if (cfg_hit) begin
        for (int k = 0; k < cfg_words; k++) begin
          if (cfg_off[7:2] == 6'(k)) begin
            for (int b = 0; b < 4; b++) begin
              rd_word.entry[b] = cfg[4*k+b];
            end
          end
        end
        prdata = rd_word.raw;
      end else if (addr_hit) begin
        for (int i = 0; i < pmp_entries; i++) begin
          if (addr_off[7:2] == 6'(i)) begin
            prdata = addr[i];
          end
        end
      end else begin
        pslverr = 1'b1; // Unmapped offset.
      end
    end
  end

endmodule

// ==== logic/pmp_region_decode.sv ====
`timescale 1ns/1ps

module pmp_region_decode
  import pmp_pkg::*;
(
  input  pmp_cfg_t    cfg,
  input  logic [31:0] addr,
  input  logic [31:0] prev_addr,
  output pmp_region_t region
);

  // Only bits 29:0 of pmpaddr name a word inside the 32-bit space.
  localparam logic [31:0] space_words = 32'h4000_0000;

  logic [30:0] cur_word;
  logic [30:0] prev_word;
  logic [31:0] napot_word;
  logic [31:0] napot_mask;
  logic [31:0] napot_lo;
  logic [31:0] napot_end;

  assign cur_word  = {1'b0, addr[29:0]};
  assign prev_word = {1'b0, prev_addr[29:0]};

  // Trailing ones plus the zero above them give the block size minus one.
  always_comb begin
    napot_word = {2'b00, addr[29:0]};
    napot_mask = napot_word ^ (napot_word + 32'd1);
    napot_lo   = napot_word & ~napot_mask;
    napot_end  = napot_lo + napot_mask + 32'd1;
    if (napot_end > space_words) begin
      napot_end = space_words; // A block wider than the space covers all of it.
    end
  end

  always_comb begin
    region = '0;
    case (cfg.a)
      pmp_tor: begin
        region.lo     = prev_word;
        region.hi     = cur_word;
        region.active = prev_word < cur_word;
      end
      pmp_na4: begin
        region.lo     = cur_word;
        region.hi     = cur_word + 31'd1;
        region.active = 1'b1;
      end
      pmp_napot: begin
        region.lo     = napot_lo[30:0];
        region.hi     = napot_end[30:0];
        region.active = 1'b1;
      end
      default: begin
        region = '0;
      end
    endcase
  end

endmodule

// ==== logic/pmp_pkg.sv ====
package pmp_pkg;

  // Address-matching mode held in the A field of each pmpcfg byte.
  typedef enum logic [1:0] {
    pmp_off   = 2'd0,
    pmp_tor   = 2'd1,
    pmp_na4   = 2'd2,
    pmp_napot = 2'd3
  } pmp_mode_e;

  typedef enum logic [1:0] {
    priv_user       = 2'd0,
    priv_supervisor = 2'd1,
    priv_machine    = 2'd3
  } priv_e;

  typedef struct packed {
    logic      l;
    logic [1:0] rsvd; // Always zero in the stored copy.
    pmp_mode_e a;
    logic      x;
    logic      w;
    logic      r;
  } pmp_cfg_t;

  // One pmpcfg word, seen either as bus data or as four entry bytes.
  typedef union packed {
    logic [31:0]        raw;
    pmp_cfg_t [3:0]     entry; // Entry 0 is the low byte.
  } pmp_cfg_word_u;

  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
    logic        instr;
    logic        write; // Instr and write both clear means a load.
    priv_e       priv;
  } pmp_req_t;

  typedef struct packed {
    logic        valid;
    logic        fault;
    logic [3:0]  cause;
    logic [31:0] tval;
  } pmp_rsp_t;

  // Bounds are word addresses; hi is exclusive so it can reach 2^30.
  typedef struct packed {
    logic        active;
    logic [30:0] lo;
    logic [30:0] hi;
  } pmp_region_t;

  localparam logic [3:0] cause_instr_fault = 4'd1;
  localparam logic [3:0] cause_load_fault  = 4'd5;
  localparam logic [3:0] cause_store_fault = 4'd7;

  localparam logic [7:0] cfg_base  = 8'h00;
  localparam logic [7:0] addr_base = 8'h40;

endpackage
